// File: hdl/command_translator.sv
/*
 * Opcode to execution unit command. Register and immediate forms map to
 * the same command; opcodes that need no unit give CMD_NONE.
 */

`timescale 1ns/1ps

module command_translator (
    input  issue_pkg::opcode_t  i_opcode,
    output issue_pkg::alu_cmd_t o_cmd
);

    always_comb begin
        case (i_opcode)
            // LUI and AUIPC reduce to an add with the immediate
            issue_pkg::OP_LUI,
            issue_pkg::OP_AUIPC,
            issue_pkg::OP_ADD,
            issue_pkg::OP_ADDI:   o_cmd = issue_pkg::CMD_ADD;
            issue_pkg::OP_SUB:    o_cmd = issue_pkg::CMD_SUB;
            issue_pkg::OP_AND,
            issue_pkg::OP_ANDI:   o_cmd = issue_pkg::CMD_AND;
            issue_pkg::OP_OR,
            issue_pkg::OP_ORI:    o_cmd = issue_pkg::CMD_OR;
            issue_pkg::OP_XOR,
            issue_pkg::OP_XORI:   o_cmd = issue_pkg::CMD_XOR;

            // Compare unit
            issue_pkg::OP_SLT,
            issue_pkg::OP_SLTI:   o_cmd = issue_pkg::CMD_SLT;
            issue_pkg::OP_SLTU,
            issue_pkg::OP_SLTIU:  o_cmd = issue_pkg::CMD_SLTU;
            issue_pkg::OP_BEQ:    o_cmd = issue_pkg::CMD_BEQ;
            issue_pkg::OP_BNE:    o_cmd = issue_pkg::CMD_BNE;
            issue_pkg::OP_BLT:    o_cmd = issue_pkg::CMD_BLT;
            issue_pkg::OP_BGE:    o_cmd = issue_pkg::CMD_BGE;
            issue_pkg::OP_BLTU:   o_cmd = issue_pkg::CMD_BLTU;
            issue_pkg::OP_BGEU:   o_cmd = issue_pkg::CMD_BGEU;

            // Shift and mul/div pair
            issue_pkg::OP_SLL,
            issue_pkg::OP_SLLI:   o_cmd = issue_pkg::CMD_SLL;
            issue_pkg::OP_SRL,
            issue_pkg::OP_SRLI:   o_cmd = issue_pkg::CMD_SRL;
            issue_pkg::OP_SRA,
            issue_pkg::OP_SRAI:   o_cmd = issue_pkg::CMD_SRA;
            issue_pkg::OP_MUL:    o_cmd = issue_pkg::CMD_MUL;
            issue_pkg::OP_MULH:   o_cmd = issue_pkg::CMD_MULH;
            issue_pkg::OP_MULHU:  o_cmd = issue_pkg::CMD_MULHU;
            issue_pkg::OP_MULHSU: o_cmd = issue_pkg::CMD_MULHSU;
            issue_pkg::OP_DIV:    o_cmd = issue_pkg::CMD_DIV;
            issue_pkg::OP_DIVU:   o_cmd = issue_pkg::CMD_DIVU;
            issue_pkg::OP_REM:    o_cmd = issue_pkg::CMD_REM;
            issue_pkg::OP_REMU:   o_cmd = issue_pkg::CMD_REMU;

            // NOP, FENCE and jumps
            default:              o_cmd = issue_pkg::CMD_NONE;
        endcase
    end

endmodule

// File: hdl/dispatch_stage.sv
/*
 * Dispatch stage. Picks the physical unit for the buffered instruction,
 * registers its operands, command and rd onto that unit's bus with a
 * one-cycle valid, and releases the buffer slot. Also forms halt.
 */

`timescale 1ns/1ps
`include "issue_defines.svh"

module dispatch_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          i_flush,

    // Buffered instruction
    input  logic                          i_buf_valid,
    input  logic                          i_buf_illegal,
    input  logic [`ISSUE_REG_ADDR_W-1:0]  i_buf_rd,
    input  logic [`ISSUE_XLEN-1:0]        i_buf_imm,

    // Decode of the buffered opcode
    input  issue_pkg::unit_class_t        i_unit_class,
    input  logic                          i_arg1_imm,
    input  issue_pkg::alu_cmd_t           i_cmd,

    // Register file read data, same cycle
    input  logic [`ISSUE_XLEN-1:0]        i_reg_rd0,
    input  logic [`ISSUE_XLEN-1:0]        i_reg_rd1,

    // Unit status
    input  logic [`ISSUE_NUM_UNITS-1:0]   i_unit_busy,
    input  logic [`ISSUE_NUM_UNITS-1:0]   i_unit_error,

    output logic                          o_release,

    // Unit buses
    output logic [`ISSUE_NUM_UNITS-1:0]   o_unit_valid,
    output issue_pkg::alu_cmd_t           o_unit_cmd  [`ISSUE_NUM_UNITS],
    output logic [`ISSUE_XLEN-1:0]        o_unit_arg0 [`ISSUE_NUM_UNITS],
    output logic [`ISSUE_XLEN-1:0]        o_unit_arg1 [`ISSUE_NUM_UNITS],
    output logic [`ISSUE_REG_ADDR_W-1:0]  o_unit_rd   [`ISSUE_NUM_UNITS],

    output logic                          o_halt
);

    logic [`ISSUE_NUM_UNITS-1:0] target_mask;
    logic                        needs_unit;
    logic                        target_free;
    logic                        fire;
    logic [`ISSUE_XLEN-1:0]      arg1_value;

    // One-hot physical unit for the current class
    always_comb begin
        target_mask = '0;
        needs_unit  = 1'b1;
        case (i_unit_class)
            issue_pkg::UNIT_ARITH:   target_mask[0] = 1'b1;
            issue_pkg::UNIT_COMPARE: target_mask[1] = 1'b1;
            issue_pkg::UNIT_SHIFT_MULDIV: begin
                // Unit 2 first, unit 3 only when 2 is taken
                if (!i_unit_busy[2]) begin
                    target_mask[2] = 1'b1;
                end else begin
                    target_mask[3] = 1'b1;
                end
            end
            default:                 needs_unit = 1'b0;
        endcase
    end

    assign target_free = |(target_mask & ~i_unit_busy);

    // Illegal instructions never reach a unit
    assign fire = i_buf_valid & ~i_buf_illegal & needs_unit & target_free & ~i_flush;

    // Slot frees on dispatch, or right away when nothing will execute it
    assign o_release = i_buf_valid & (i_buf_illegal | ~needs_unit | target_free);

    assign arg1_value = i_arg1_imm ? i_buf_imm : i_reg_rd1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_unit_valid <= '0;
        end else if (i_flush) begin
            o_unit_valid <= '0;
        end else if (fire) begin
            o_unit_valid <= target_mask;
        end else begin
            o_unit_valid <= '0;
        end
    end

    // Only the chosen unit's bus is updated
    always_ff @(posedge clk) begin
        for (int n = 0; n < `ISSUE_NUM_UNITS; n++) begin
            if (fire && target_mask[n]) begin
                o_unit_cmd[n]  <= i_cmd;
                o_unit_arg0[n] <= i_reg_rd0;
                o_unit_arg1[n] <= arg1_value;
                o_unit_rd[n]   <= i_buf_rd;
            end
        end
    end

    // Illegal instruction sits in the buffer for one cycle only
    assign o_halt = (i_buf_valid & i_buf_illegal) | (|i_unit_error);

endmodule

// File: hdl/issue_buffer.sv
/*
 * One-entry issue buffer. Captures a decoded instruction when the decoder
 * strobes valid and the slot is free or being released, and holds it
 * until the dispatch stage releases it or a flush empties it.
 */

`timescale 1ns/1ps
`include "issue_defines.svh"

module issue_buffer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          i_flush,
    input  logic                          i_dec_valid,
    input  issue_pkg::opcode_t            i_dec_opcode,
    input  logic [`ISSUE_REG_ADDR_W-1:0]  i_dec_rs1,
    input  logic [`ISSUE_REG_ADDR_W-1:0]  i_dec_rs2,
    input  logic [`ISSUE_REG_ADDR_W-1:0]  i_dec_rd,
    input  logic [`ISSUE_XLEN-1:0]        i_dec_imm,
    input  logic                          i_dec_illegal,
    input  logic                          i_release,
    output logic                          o_dec_busy,
    output logic                          o_buf_valid,
    output issue_pkg::opcode_t            o_buf_opcode,
    output logic [`ISSUE_REG_ADDR_W-1:0]  o_buf_rs1,
    output logic [`ISSUE_REG_ADDR_W-1:0]  o_buf_rs2,
    output logic [`ISSUE_REG_ADDR_W-1:0]  o_buf_rd,
    output logic [`ISSUE_XLEN-1:0]        o_buf_imm,
    output logic                          o_buf_illegal
);

    logic load;

    // Slot is blocked only while it holds something that stays this cycle
    assign o_dec_busy = o_buf_valid & ~i_release;

    // A flush drops whatever the decoder offers in the same cycle
    assign load = i_dec_valid & ~o_dec_busy & ~i_flush;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_buf_valid <= 1'b0;
        end else if (i_flush) begin
            o_buf_valid <= 1'b0;
        end else if (load) begin
            o_buf_valid <= 1'b1;
        end else if (i_release) begin
            o_buf_valid <= 1'b0;
        end
    end

    // Instruction fields, only meaningful while valid
    always_ff @(posedge clk) begin
        if (load) begin
            o_buf_opcode  <= i_dec_opcode;
            o_buf_rs1     <= i_dec_rs1;
            o_buf_rs2     <= i_dec_rs2;
            o_buf_rd      <= i_dec_rd;
            o_buf_imm     <= i_dec_imm;
            o_buf_illegal <= i_dec_illegal;
        end
    end

endmodule

// File: hdl/issue_defines.svh
/*
 * Width and size constants for the issue stage.
 * Included by every RTL block that sizes a port or a register.
 */

`ifndef ISSUE_DEFINES_SVH
`define ISSUE_DEFINES_SVH

// Data word width
`define ISSUE_XLEN 32

// Register index width, 32 architectural registers
`define ISSUE_REG_ADDR_W 5

// Execution units behind the issuer
// Units 0 and 1 are single, units 2 and 3 form the shift/muldiv pair
`define ISSUE_NUM_UNITS 4

`endif

// File: hdl/issue_pkg.sv
/*
 * Shared types of the issue stage: decoded opcodes, unit commands
 * and target unit classes. The enum order is the numeric encoding.
 */

package issue_pkg;

    // Decoded instruction kinds
    typedef enum logic [5:0] {
        OP_NOP, OP_FENCE, OP_JAL, OP_JALR,
        OP_LUI, OP_AUIPC,
        OP_ADD, OP_ADDI, OP_SUB,
        OP_AND, OP_ANDI, OP_OR, OP_ORI, OP_XOR, OP_XORI,
        OP_SLT, OP_SLTI, OP_SLTU, OP_SLTIU,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_SLL, OP_SLLI, OP_SRL, OP_SRLI, OP_SRA, OP_SRAI,
        OP_MUL, OP_MULH, OP_MULHU, OP_MULHSU,
        OP_DIV, OP_DIVU, OP_REM, OP_REMU
    } opcode_t;

    // Commands seen by the execution units
    typedef enum logic [4:0] {
        CMD_NONE,
        CMD_ADD,
        CMD_SUB,
        CMD_AND,
        CMD_OR,
        CMD_XOR,
        CMD_SLT,
        CMD_SLTU,
        CMD_BEQ,
        CMD_BNE,
        CMD_BLT,
        CMD_BGE,
        CMD_BLTU,
        CMD_BGEU,
        CMD_SLL,
        CMD_SRL,
        CMD_SRA,
        CMD_MUL,
        CMD_MULH,
        CMD_MULHU,
        CMD_MULHSU,
        CMD_DIV,
        CMD_DIVU,
        CMD_REM,
        CMD_REMU
    } alu_cmd_t;

    // Which kind of unit executes an opcode
    typedef enum logic [1:0] {
        UNIT_NONE,
        UNIT_ARITH,         // unit 0
        UNIT_COMPARE,       // unit 1
        UNIT_SHIFT_MULDIV   // unit 2, else unit 3
    } unit_class_t;

endpackage

// File: hdl/issuer.sv
/*
 * Issue stage top level. Buffers one decoded instruction, reads its sources
 * from the register file and dispatches it to one of four execution units.
 * Decoder handshake is valid with busy back-pressure.
 */

`timescale 1ns/1ps
`include "issue_defines.svh"

module issuer (
    input  logic                          clk,
    input  logic                          rst_n,

    // Decoder
    input  logic                          i_dec_valid,
    input  issue_pkg::opcode_t            i_dec_opcode,
    input  logic [`ISSUE_REG_ADDR_W-1:0]  i_dec_rs1,
    input  logic [`ISSUE_REG_ADDR_W-1:0]  i_dec_rs2,
    input  logic [`ISSUE_REG_ADDR_W-1:0]  i_dec_rd,
    input  logic [`ISSUE_XLEN-1:0]        i_dec_imm,
    input  logic                          i_dec_illegal,
    output logic                          o_dec_busy,

    // Register file
    output logic [`ISSUE_REG_ADDR_W-1:0]  o_reg_ra0,
    output logic [`ISSUE_REG_ADDR_W-1:0]  o_reg_ra1,
    input  logic [`ISSUE_XLEN-1:0]        i_reg_rd0,
    input  logic [`ISSUE_XLEN-1:0]        i_reg_rd1,

    // Execution units
    output logic [`ISSUE_NUM_UNITS-1:0]   o_unit_valid,
    output issue_pkg::alu_cmd_t           o_unit_cmd  [`ISSUE_NUM_UNITS],
    output logic [`ISSUE_XLEN-1:0]        o_unit_arg0 [`ISSUE_NUM_UNITS],
    output logic [`ISSUE_XLEN-1:0]        o_unit_arg1 [`ISSUE_NUM_UNITS],
    output logic [`ISSUE_REG_ADDR_W-1:0]  o_unit_rd   [`ISSUE_NUM_UNITS],
    input  logic [`ISSUE_NUM_UNITS-1:0]   i_unit_busy,
    input  logic [`ISSUE_NUM_UNITS-1:0]   i_unit_error,

    // Control
    input  logic                          i_flush,
    output logic                          o_halt
);

    logic                         buf_valid;
    issue_pkg::opcode_t           buf_opcode;
    logic [`ISSUE_REG_ADDR_W-1:0] buf_rd;
    logic [`ISSUE_XLEN-1:0]       buf_imm;
    logic                         buf_illegal;
    logic                         release_slot;
    issue_pkg::unit_class_t       unit_class;
    logic                         arg1_imm;
    issue_pkg::alu_cmd_t          cmd;

    // Source indices feed the register file directly
    issue_buffer u_buffer (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_flush       (i_flush),
        .i_dec_valid   (i_dec_valid),
        .i_dec_opcode  (i_dec_opcode),
        .i_dec_rs1     (i_dec_rs1),
        .i_dec_rs2     (i_dec_rs2),
        .i_dec_rd      (i_dec_rd),
        .i_dec_imm     (i_dec_imm),
        .i_dec_illegal (i_dec_illegal),
        .i_release     (release_slot),
        .o_dec_busy    (o_dec_busy),
        .o_buf_valid   (buf_valid),
        .o_buf_opcode  (buf_opcode),
        .o_buf_rs1     (o_reg_ra0),
        .o_buf_rs2     (o_reg_ra1),
        .o_buf_rd      (buf_rd),
        .o_buf_imm     (buf_imm),
        .o_buf_illegal (buf_illegal)
    );

    unit_selector u_selector (
        .i_opcode     (buf_opcode),
        .o_unit_class (unit_class),
        .o_arg1_imm   (arg1_imm)
    );

    command_translator u_translator (
        .i_opcode (buf_opcode),
        .o_cmd    (cmd)
    );

    dispatch_stage u_dispatch (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_flush       (i_flush),
        .i_buf_valid   (buf_valid),
        .i_buf_illegal (buf_illegal),
        .i_buf_rd      (buf_rd),
        .i_buf_imm     (buf_imm),
        .i_unit_class  (unit_class),
        .i_arg1_imm    (arg1_imm),
        .i_cmd         (cmd),
        .i_reg_rd0     (i_reg_rd0),
        .i_reg_rd1     (i_reg_rd1),
        .i_unit_busy   (i_unit_busy),
        .i_unit_error  (i_unit_error),
        .o_release     (release_slot),
        .o_unit_valid  (o_unit_valid),
        .o_unit_cmd    (o_unit_cmd),
        .o_unit_arg0   (o_unit_arg0),
        .o_unit_arg1   (o_unit_arg1),
        .o_unit_rd     (o_unit_rd),
        .o_halt        (o_halt)
    );

endmodule

// File: hdl/unit_selector.sv
/*
 * Opcode to unit class decode for the buffered instruction, plus the
 * flag that puts the immediate on argument 1. Purely combinational.
 */

`timescale 1ns/1ps

module unit_selector (
    input  issue_pkg::opcode_t     i_opcode,
    output issue_pkg::unit_class_t o_unit_class,
    output logic                   o_arg1_imm
);

    always_comb begin
        o_unit_class = issue_pkg::UNIT_NONE;
        o_arg1_imm   = 1'b0;

        case (i_opcode)
            // Arithmetic and logic, immediate forms
            issue_pkg::OP_LUI,
            issue_pkg::OP_AUIPC,
            issue_pkg::OP_ADDI,
            issue_pkg::OP_ANDI,
            issue_pkg::OP_ORI,
            issue_pkg::OP_XORI: begin
                o_unit_class = issue_pkg::UNIT_ARITH;
                o_arg1_imm   = 1'b1;
            end
            issue_pkg::OP_ADD,
            issue_pkg::OP_SUB,
            issue_pkg::OP_AND,
            issue_pkg::OP_OR,
            issue_pkg::OP_XOR: begin
                o_unit_class = issue_pkg::UNIT_ARITH;
            end

            // Set-less-than and all branch compares go to unit 1
            issue_pkg::OP_SLTI,
            issue_pkg::OP_SLTIU: begin
                o_unit_class = issue_pkg::UNIT_COMPARE;
                o_arg1_imm   = 1'b1;
            end
            issue_pkg::OP_SLT,
            issue_pkg::OP_SLTU,
            issue_pkg::OP_BEQ,
            issue_pkg::OP_BNE,
            issue_pkg::OP_BLT,
            issue_pkg::OP_BGE,
            issue_pkg::OP_BLTU,
            issue_pkg::OP_BGEU: begin
                o_unit_class = issue_pkg::UNIT_COMPARE;
            end

            // Shifts and mul/div, served by the unit pair
            issue_pkg::OP_SLLI,
            issue_pkg::OP_SRLI,
            issue_pkg::OP_SRAI: begin
                o_unit_class = issue_pkg::UNIT_SHIFT_MULDIV;
                o_arg1_imm   = 1'b1;
            end
            issue_pkg::OP_SLL, issue_pkg::OP_SRL, issue_pkg::OP_SRA,
            issue_pkg::OP_MUL, issue_pkg::OP_MULH,
            issue_pkg::OP_MULHU, issue_pkg::OP_MULHSU,
            issue_pkg::OP_DIV, issue_pkg::OP_DIVU,
            issue_pkg::OP_REM, issue_pkg::OP_REMU: begin
                o_unit_class = issue_pkg::UNIT_SHIFT_MULDIV;
            end

            // NOP, FENCE, JAL, JALR need no unit
            default: begin
                o_unit_class = issue_pkg::UNIT_NONE;
            end
        endcase
    end

endmodule

// File: list.f
+incdir+hdl
hdl/issue_pkg.sv
hdl/issue_buffer.sv
hdl/unit_selector.sv
hdl/command_translator.sv
hdl/dispatch_stage.sv
hdl/issuer.sv
testbench/issue_checker.sv
testbench/tb_issuer.sv

// File: run.sh
#!/bin/sh
# Build and run the issue stage testbench, then look for the pass line in its output
cd "$(dirname "$0")" &&
verilator --binary --timing -f list.f --top-module tb_issuer -o sim_issuer &&
out="$(./obj_dir/sim_issuer)" &&
printf '%s\n' "$out" &&
printf '%s\n' "$out" | grep -q "TEST OK" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: testbench/issue_checker.sv
/*
 * Result checker for the issue stage testbench. Records unit strobes, halt
 * and decoder busy while a test runs, then compares them with the expected
 * fields when the testbench marks the end of the test.
 */

`timescale 1ns/1ps
`include "issue_defines.svh"

module issue_checker (
    input  logic                          clk,
    input  logic [`ISSUE_NUM_UNITS-1:0]   i_unit_valid,
    input  issue_pkg::alu_cmd_t           i_unit_cmd  [`ISSUE_NUM_UNITS],
    input  logic [`ISSUE_XLEN-1:0]        i_unit_arg0 [`ISSUE_NUM_UNITS],
    input  logic [`ISSUE_XLEN-1:0]        i_unit_arg1 [`ISSUE_NUM_UNITS],
    input  logic [`ISSUE_REG_ADDR_W-1:0]  i_unit_rd   [`ISSUE_NUM_UNITS],
    input  logic                          i_halt,
    input  logic                          i_dec_busy,
    input  logic [127:0]                  i_test_name,
    input  logic                          i_hold,
    input  logic                          i_test_end,
    input  int                            i_exp_unit,
    input  int                            i_exp_cmd,
    input  logic [`ISSUE_XLEN-1:0]        i_exp_arg0,
    input  logic [`ISSUE_XLEN-1:0]        i_exp_arg1,
    input  logic [`ISSUE_REG_ADDR_W-1:0]  i_exp_rd,
    input  int                            i_exp_halt,
    input  int                            i_exp_stall,
    output logic                          o_seen,
    output int                            o_pass_count,
    output int                            o_fail_count
);

    int          strobes    = 0;
    int          seen_unit  = 0;
    int          seen_cmd   = 0;
    logic [31:0] seen_arg0  = '0;
    logic [31:0] seen_arg1  = '0;
    logic [31:0] seen_rd    = '0;
    int          halt_seen  = 0;
    int          stall_seen = 0;
    int          pass_count = 0;
    int          fail_count = 0;

    assign o_seen       = (strobes != 0);
    assign o_pass_count = pass_count;
    assign o_fail_count = fail_count;

    function automatic int compare_field(input string field, input logic [31:0] expected,
                                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %0s %0s: expected 0x%08h actual 0x%08h",
                     i_test_name, field, expected, actual);
            return 1;
        end
        return 0;
    endfunction

    task automatic report_test();
        int errs;
        errs = 0;
        if (i_exp_unit == 9) begin
            errs += compare_field("strobes", 32'd0, strobes);
        end else if (strobes == 0) begin
            $display("Test %0s: no dispatch appeared within the wait limit", i_test_name);
            errs++;
        end else begin
            errs += compare_field("strobes", 32'd1, strobes);
            errs += compare_field("unit", i_exp_unit, seen_unit);
            errs += compare_field("cmd", i_exp_cmd, seen_cmd);
            errs += compare_field("arg0", i_exp_arg0, seen_arg0);
            errs += compare_field("arg1", i_exp_arg1, seen_arg1);
            errs += compare_field("rd", 32'(i_exp_rd), seen_rd);
        end
        errs += compare_field("halt", i_exp_halt, halt_seen);
        errs += compare_field("decoder busy", i_exp_stall, stall_seen);
        // Every test should leave the buffer empty
        if (i_dec_busy) begin
            $display("Test %0s: buffer did not drain, decoder busy still high", i_test_name);
            errs++;
        end
        if (errs == 0) begin
            pass_count++;
            $display("[pass] %0s", i_test_name);
        end else begin
            fail_count++;
            $display("[fail] %0s with %0d problems", i_test_name, errs);
        end
        strobes    = 0;
        halt_seen  = 0;
        stall_seen = 0;
    endtask

    // Sampled mid-cycle, away from the edges where inputs change
    always @(negedge clk) begin
        if (i_test_end) begin
            report_test();
        end else begin
            for (int n = 0; n < `ISSUE_NUM_UNITS; n++) begin
                if (i_unit_valid[n]) begin
                    if (strobes == 0) begin
                        seen_unit = n;
                        seen_cmd  = int'(i_unit_cmd[n]);
                        seen_arg0 = i_unit_arg0[n];
                        seen_arg1 = i_unit_arg1[n];
                        seen_rd   = 32'(i_unit_rd[n]);
                    end
                    strobes++;
                end
            end
            if (i_halt) begin
                halt_seen = 1;
            end
            if (i_hold && i_dec_busy) begin
                stall_seen = 1;
            end
        end
    end

endmodule

// File: testbench/issue_stimulus.txt
# name op rs1 rs2 rd imm illegal busy error flush | unit cmd arg0 arg1 halt busy_seen
# op/cmd in enum order, imm/arg hex, busy/error masks binary unit3..unit0, unit 9 = none
add       6  1  2  5 00000777 0 0000 0000 0 0  1 01010101 02020202 0 0
addi      7  3  0  6 00000123 0 0000 0000 0 0  1 03030303 00000123 0 0
sub       8  4  5  7 00000777 0 0000 0000 0 0  2 04040404 05050505 0 0
and       9  1  3  8 00000777 0 0000 0000 0 0  3 01010101 03030303 0 0
andi     10  2  0  9 0000ff00 0 0000 0000 0 0  3 02020202 0000ff00 0 0
or       11  6  7 10 00000777 0 0000 0000 0 0  4 06060606 07070707 0 0
ori      12  0  0 11 00000055 0 0000 0000 0 0  4 00000000 00000055 0 0
xor      13  8  9 12 00000777 0 0000 0000 0 0  5 08080808 09090909 0 0
xori     14 10  0 13 fffff800 0 0000 0000 0 0  5 0a0a0a0a fffff800 0 0
slt      15  1  2  3 00000777 0 0000 0000 0 1  6 01010101 02020202 0 0
slti     16  2  0  4 fffffff0 0 0000 0000 0 1  6 02020202 fffffff0 0 0
sltu     17  3  4  5 00000777 0 0000 0000 0 1  7 03030303 04040404 0 0
sltiu    18  5  0  6 00000010 0 0000 0000 0 1  7 05050505 00000010 0 0
beq      19  6  7  0 00000040 0 0000 0000 0 1  8 06060606 07070707 0 0
bne      20  8  9  0 00000040 0 0000 0000 0 1  9 08080808 09090909 0 0
blt      21 10 11  0 00000040 0 0000 0000 0 1 10 0a0a0a0a 0b0b0b0b 0 0
bge      22 12 13  0 00000040 0 0000 0000 0 1 11 0c0c0c0c 0d0d0d0d 0 0
bltu     23 14 15  0 00000040 0 0000 0000 0 1 12 0e0e0e0e 0f0f0f0f 0 0
bgeu     24 16 17  0 00000040 0 0000 0000 0 1 13 10101010 11111111 0 0
sll      25  1  2  7 00000777 0 0000 0000 0 2 14 01010101 02020202 0 0
srai     30  3  0  8 00000004 0 0100 0000 0 3 16 03030303 00000004 0 0
mul_wait 31  4  5  9 00000777 0 1100 0000 0 2 17 04040404 05050505 0 1
divu     36  6  7 10 00000777 0 1000 0000 0 2 22 06060606 07070707 0 0
nop       0  0  0  0 00000000 0 0000 0000 0 9  0 00000000 00000000 0 0
fence     1  0  0  0 00000000 0 0000 0000 0 9  0 00000000 00000000 0 0
jal       2  0  0  1 00000100 0 0000 0000 0 9  0 00000000 00000000 0 0
jalr      3  5  0  1 00000008 0 0000 0000 0 9  0 00000000 00000000 0 0
illegal   6  1  2  3 00000777 1 0000 0000 0 9  0 00000000 00000000 1 0
unit_err  0  0  0  0 00000000 0 0000 0100 0 9  0 00000000 00000000 1 0
flush     6  1  2  3 00000777 0 0001 0000 1 9  0 00000000 00000000 0 1

// File: testbench/tb_issuer.sv
/*
 * Testbench for the issue stage. Reads one test per line from the stimulus
 * file, drives the decoder and the unit status, models the register file
 * and hands the expected results to issue_checker.
 */

`timescale 1ns/1ps
`include "issue_defines.svh"

module tb_issuer;

    localparam string STIM_FILE   = "testbench/issue_stimulus.txt";
    localparam int    HOLD_CYCLES = 3;
    localparam int    WAIT_LIMIT  = 8;
    localparam int    NO_UNIT     = 9;

    logic                         clk;
    logic                         rst_n;
    logic                         dec_valid;
    issue_pkg::opcode_t           dec_opcode;
    logic [`ISSUE_REG_ADDR_W-1:0] dec_rs1;
    logic [`ISSUE_REG_ADDR_W-1:0] dec_rs2;
    logic [`ISSUE_REG_ADDR_W-1:0] dec_rd;
    logic [`ISSUE_XLEN-1:0]       dec_imm;
    logic                         dec_illegal;
    logic                         dec_busy;
    logic [`ISSUE_REG_ADDR_W-1:0] reg_ra0;
    logic [`ISSUE_REG_ADDR_W-1:0] reg_ra1;
    logic [`ISSUE_XLEN-1:0]       reg_rd0;
    logic [`ISSUE_XLEN-1:0]       reg_rd1;
    logic [`ISSUE_NUM_UNITS-1:0]  unit_valid;
    issue_pkg::alu_cmd_t          unit_cmd  [`ISSUE_NUM_UNITS];
    logic [`ISSUE_XLEN-1:0]       unit_arg0 [`ISSUE_NUM_UNITS];
    logic [`ISSUE_XLEN-1:0]       unit_arg1 [`ISSUE_NUM_UNITS];
    logic [`ISSUE_REG_ADDR_W-1:0] unit_rd   [`ISSUE_NUM_UNITS];
    logic [`ISSUE_NUM_UNITS-1:0]  unit_busy;
    logic [`ISSUE_NUM_UNITS-1:0]  unit_error;
    logic                         flush;
    logic                         halt;

    // Fields of the current stimulus line
    logic [127:0]                 test_name;
    int                           op, rs1, rs2, rd, ill, do_flush;
    logic [`ISSUE_XLEN-1:0]       imm;
    logic [3:0]                   busy_mask;
    logic [3:0]                   err_mask;
    int                           exp_unit, exp_cmd, exp_halt, exp_stall;
    logic [`ISSUE_XLEN-1:0]       exp_arg0;
    logic [`ISSUE_XLEN-1:0]       exp_arg1;
    logic [`ISSUE_REG_ADDR_W-1:0] exp_rd;

    logic hold;
    logic test_end;
    logic dispatch_seen;
    int   pass_count;
    int   fail_count;
    int   cycle_count = 0;
    int   cycle_limit = 0;

    always #4 clk = ~clk;

    // Register file model, x0 reads zero
    function automatic logic [`ISSUE_XLEN-1:0] reg_value(
        input logic [`ISSUE_REG_ADDR_W-1:0] idx
    );
        return {{(`ISSUE_XLEN-`ISSUE_REG_ADDR_W){1'b0}}, idx} * 32'h01010101;
    endfunction

    assign reg_rd0 = reg_value(reg_ra0);
    assign reg_rd1 = reg_value(reg_ra1);

    issuer dut (
        .clk (clk), .rst_n (rst_n),
        .i_dec_valid (dec_valid), .i_dec_opcode (dec_opcode),
        .i_dec_rs1 (dec_rs1), .i_dec_rs2 (dec_rs2), .i_dec_rd (dec_rd),
        .i_dec_imm (dec_imm), .i_dec_illegal (dec_illegal), .o_dec_busy (dec_busy),
        .o_reg_ra0 (reg_ra0), .o_reg_ra1 (reg_ra1),
        .i_reg_rd0 (reg_rd0), .i_reg_rd1 (reg_rd1),
        .o_unit_valid (unit_valid), .o_unit_cmd (unit_cmd),
        .o_unit_arg0 (unit_arg0), .o_unit_arg1 (unit_arg1), .o_unit_rd (unit_rd),
        .i_unit_busy (unit_busy), .i_unit_error (unit_error),
        .i_flush (flush), .o_halt (halt)
    );

    issue_checker checker_i (
        .clk (clk),
        .i_unit_valid (unit_valid), .i_unit_cmd (unit_cmd),
        .i_unit_arg0 (unit_arg0), .i_unit_arg1 (unit_arg1), .i_unit_rd (unit_rd),
        .i_halt (halt), .i_dec_busy (dec_busy),
        .i_test_name (test_name), .i_hold (hold), .i_test_end (test_end),
        .i_exp_unit (exp_unit), .i_exp_cmd (exp_cmd),
        .i_exp_arg0 (exp_arg0), .i_exp_arg1 (exp_arg1), .i_exp_rd (exp_rd),
        .i_exp_halt (exp_halt), .i_exp_stall (exp_stall),
        .o_seen (dispatch_seen), .o_pass_count (pass_count), .o_fail_count (fail_count)
    );

    // Run limit from the number of tests
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic bit is_data_line(input string s);
        return s.len() > 1 && s[0] != "#";
    endfunction

    function automatic int count_tests();
        int    fd;
        int    got;
        int    count;
        string line;
        count = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                got = $fgets(line, fd);
                if (got > 0 && is_data_line(line)) begin
                    count++;
                end
            end
            $fclose(fd);
        end
        return count;
    endfunction

    task automatic run_test();
        int waited;
        waited = 0;
        // Offer the instruction together with the unit status of this test
        dec_valid   = 1'b1;
        dec_opcode  = issue_pkg::opcode_t'(op[5:0]);
        dec_rs1     = rs1[`ISSUE_REG_ADDR_W-1:0];
        dec_rs2     = rs2[`ISSUE_REG_ADDR_W-1:0];
        dec_rd      = rd[`ISSUE_REG_ADDR_W-1:0];
        dec_imm     = imm;
        dec_illegal = ill[0];
        exp_rd      = rd[`ISSUE_REG_ADDR_W-1:0];
        unit_busy   = busy_mask;
        unit_error  = err_mask;
        hold        = 1'b1;
        @(negedge clk);
        while (dec_busy) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        dec_valid = 1'b0;
        repeat (HOLD_CYCLES) @(posedge clk);
        #1;
        if (do_flush != 0) begin
            flush = 1'b1;
            @(posedge clk);
            #1;
            flush = 1'b0;
        end
        // Units free again, a held instruction may leave now
        hold       = 1'b0;
        unit_busy  = '0;
        unit_error = '0;
        if (exp_unit != NO_UNIT) begin
            while (!dispatch_seen && waited < WAIT_LIMIT) begin
                @(posedge clk);
                waited++;
            end
            repeat (2) @(posedge clk);
        end else begin
            repeat (4) @(posedge clk);
        end
        #1;
        test_end = 1'b1;
        @(posedge clk);
        #1;
        test_end = 1'b0;
    endtask

    initial begin
        int    fd;
        int    got;
        int    fields;
        int    n_tests;
        int    bad_lines;
        string line;
        clk         = 1'b0;
        rst_n       = 1'b0;
        dec_valid   = 1'b0;
        dec_opcode  = issue_pkg::OP_NOP;
        dec_rs1     = '0;
        dec_rs2     = '0;
        dec_rd      = '0;
        dec_imm     = '0;
        dec_illegal = 1'b0;
        unit_busy   = '0;
        unit_error  = '0;
        flush       = 1'b0;
        hold        = 1'b0;
        test_end    = 1'b0;
        bad_lines   = 0;
        n_tests     = count_tests();
        cycle_limit = 20 * n_tests + 20;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        if (n_tests == 0) begin
            $display("No test lines could be read from %s", STIM_FILE);
        end else begin
            fd = $fopen(STIM_FILE, "r");
            while (!$feof(fd)) begin
                got = $fgets(line, fd);
                if (got > 0 && is_data_line(line)) begin
                    fields = $sscanf(line, "%s %d %d %d %d %h %d %b %b %d %d %d %h %h %d %d",
                                     test_name, op, rs1, rs2, rd, imm, ill, busy_mask,
                                     err_mask, do_flush, exp_unit, exp_cmd, exp_arg0,
                                     exp_arg1, exp_halt, exp_stall);
                    if (fields == 16) begin
                        run_test();
                    end else begin
                        $display("Malformed stimulus line skipped: %s", line);
                        bad_lines++;
                    end
                end
            end
            $fclose(fd);
        end
        $display("Result: %0d passed, %0d failed", pass_count, fail_count);
        if (n_tests != 0 && bad_lines == 0 && fail_count == 0 && pass_count == n_tests) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
